// File: Makefile
# Verilator flow for the path-metric normalizer

TOP := tb_pm_normalize
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/pm_max_tree.sv
`default_nettype none
`include "pm_settings.svh"

module pm_max_tree (
    input  pm_pkg::metric_t    pm_i [0:`PM_NUM_STATES-1],
    input  pm_pkg::mode_t      mode_i,
    output pm_pkg::metric_t    best_metric_o,
    output pm_pkg::state_idx_t best_index_o
);

    // Heap numbering of the tree nodes.
    // Node 1 is the root, node n has children 2n and 2n+1,
    // and leaves NUM..2*NUM-1 hold states 0..NUM-1
    localparam int NUM_NODES  = 2 * `PM_NUM_STATES;
    localparam int NUM_LEVELS = `PM_INDEX_W;

    // Subtree roots, each covering states 0 upwards
    localparam int ROOT_64 = 1;
    localparam int ROOT_32 = 2;
    localparam int ROOT_16 = 4;
    localparam int ROOT_8  = 8;

    pm_pkg::metric_t    node_metric [1:NUM_NODES-1];
    pm_pkg::state_idx_t node_index  [1:NUM_NODES-1];

    // ------------------------------------------------------------
    // Leaves
    // ------------------------------------------------------------
    for (genvar s = 0; s < `PM_NUM_STATES; s++) begin : g_leaf
        assign node_metric[`PM_NUM_STATES + s] = pm_i[s];
        assign node_index[`PM_NUM_STATES + s]  = pm_pkg::state_idx_t'(s);
    end

    // ------------------------------------------------------------
    // Compare-select levels, leaves towards root
    // ------------------------------------------------------------
    for (genvar lvl = 1; lvl <= NUM_LEVELS; lvl++) begin : g_level
        localparam int FIRST = `PM_NUM_STATES >> lvl;

        for (genvar k = 0; k < FIRST; k++) begin : g_node
            localparam int N = FIRST + k;

            logic take_left;

            // Left child holds the lower indices, so ties go left
            assign take_left = node_metric[2*N] >= node_metric[2*N+1];

            assign node_metric[N] = take_left ? node_metric[2*N] : node_metric[2*N+1];
            assign node_index[N]  = take_left ? node_index[2*N] : node_index[2*N+1];
        end
    end

    // ------------------------------------------------------------
    // Root select by active state count
    // ------------------------------------------------------------
    always_comb begin
        case (mode_i)
            pm_pkg::MODE_64: begin
                best_metric_o = node_metric[ROOT_64];
                best_index_o  = node_index[ROOT_64];
            end
            pm_pkg::MODE_32: begin
                best_metric_o = node_metric[ROOT_32];
                best_index_o  = node_index[ROOT_32];
            end
            pm_pkg::MODE_16: begin
                best_metric_o = node_metric[ROOT_16];
                best_index_o  = node_index[ROOT_16];
            end
            default: begin
                best_metric_o = node_metric[ROOT_8];
                best_index_o  = node_index[ROOT_8];
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/pm_metric_regs.sv
`default_nettype none
`include "pm_settings.svh"

module pm_metric_regs (
    input  logic               clk_i,
    input  logic               rst_an_i,
    input  logic               en_i,
    input  logic               clear_i,
    input  pm_pkg::mode_t      mode_i,
    input  pm_pkg::metric_t    pm_i [0:`PM_NUM_STATES-1],
    input  pm_pkg::metric_t    best_metric_i,
    input  pm_pkg::state_idx_t best_index_i,
    output pm_pkg::metric_t    pm_nom_o [0:`PM_NUM_STATES-1],
    output pm_pkg::state_idx_t best_state_o
);

    // One bit more than an index, so the full count fits
    localparam int CNT_W = `PM_INDEX_W + 1;

    logic [CNT_W-1:0]          active_cnt;
    logic [`PM_NUM_STATES-1:0] upd_en;
    pm_pkg::metric_t           sat_val [0:`PM_NUM_STATES-1];

    // ------------------------------------------------------------
    // Active state count
    // ------------------------------------------------------------
    always_comb begin
        case (mode_i)
            pm_pkg::MODE_64: active_cnt = CNT_W'(`PM_NUM_STATES);
            pm_pkg::MODE_32: active_cnt = CNT_W'(`PM_NUM_STATES / 2);
            pm_pkg::MODE_16: active_cnt = CNT_W'(`PM_NUM_STATES / 4);
            default:         active_cnt = CNT_W'(`PM_NUM_STATES / 8);
        endcase
    end

    // ------------------------------------------------------------
    // Per state subtract and saturate
    // ------------------------------------------------------------
    for (genvar s = 0; s < `PM_NUM_STATES; s++) begin : g_state
        pm_pkg::nom_diff_t diff;

        assign upd_en[s] = CNT_W'(s) < active_cnt;

        // Both operands sign extended first
        assign diff = pm_pkg::nom_diff_t'(pm_i[s]) - pm_pkg::nom_diff_t'(best_metric_i);

        assign sat_val[s] = (diff > `PM_SAT_HI) ? pm_pkg::metric_t'(`PM_SAT_HI) :
                            (diff < `PM_SAT_LO) ? pm_pkg::metric_t'(`PM_SAT_LO) :
                            pm_pkg::metric_t'(diff);
    end

    // ------------------------------------------------------------
    // Metric bank, inactive states hold
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            pm_nom_o <= '{default: '0};
        end else if (clear_i) begin
            pm_nom_o <= '{default: '0};
        end else if (en_i) begin
            for (int s = 0; s < `PM_NUM_STATES; s++) begin
                if (upd_en[s]) begin
                    pm_nom_o[s] <= sat_val[s];
                end
            end
        end
    end

    // Best state index
    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            best_state_o <= '0;
        end else if (clear_i) begin
            best_state_o <= '0;
        end else if (en_i) begin
            best_state_o <= best_index_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/pm_normalize_top.sv
`default_nettype none
`include "pm_settings.svh"

module pm_normalize_top (
    input  logic               clk_i,
    input  logic               rst_an_i,
    input  logic               en_i,
    input  logic               clear_i,
    input  pm_pkg::mode_t      mode_i,
    input  pm_pkg::metric_t    pm_i [0:`PM_NUM_STATES-1],
    output pm_pkg::metric_t    pm_nom_o [0:`PM_NUM_STATES-1],
    output pm_pkg::state_idx_t best_state_o
);

    // Tree result, valid in the same cycle as pm_i
    pm_pkg::metric_t    best_metric;
    pm_pkg::state_idx_t best_index;

    // ------------------------------------------------------------
    // Compare-select over the active states
    // ------------------------------------------------------------
    pm_max_tree u_max_tree (
        .pm_i          (pm_i),
        .mode_i        (mode_i),
        .best_metric_o (best_metric),
        .best_index_o  (best_index)
    );

    // ------------------------------------------------------------
    // Normalize and register
    // ------------------------------------------------------------
    pm_metric_regs u_metric_regs (
        .clk_i         (clk_i),
        .rst_an_i      (rst_an_i),
        .en_i          (en_i),
        .clear_i       (clear_i),
        .mode_i        (mode_i),
        .pm_i          (pm_i),
        .best_metric_i (best_metric),
        .best_index_i  (best_index),
        .pm_nom_o      (pm_nom_o),
        .best_state_o  (best_state_o)
    );

endmodule

`default_nettype wire

// File: hw/pm_pkg.sv
`default_nettype none
`include "pm_settings.svh"

package pm_pkg;

    // Signed path metric, raw and normalized arrays alike
    typedef logic signed [`PM_METRIC_W-1:0] metric_t;

    // Metric minus best metric, one guard bit ahead of saturation
    typedef logic signed [`PM_METRIC_W:0] nom_diff_t;

    typedef logic [`PM_INDEX_W-1:0] state_idx_t;

    // Number of active states, always counted from state 0
    typedef enum logic [1:0] {
        MODE_64 = 2'd0,
        MODE_32 = 2'd1,
        MODE_16 = 2'd2,
        MODE_8  = 2'd3
    } mode_t;

endpackage

`default_nettype wire

// File: hw/pm_settings.svh
`ifndef PM_SETTINGS_SVH
`define PM_SETTINGS_SVH

// Trellis size
`define PM_NUM_STATES 64

// Incoming path metric, two's complement
`define PM_METRIC_W 9

// Bits needed to name one state
`define PM_INDEX_W 6

// Clip range of a normalized metric
`define PM_SAT_HI 127
`define PM_SAT_LO (-128)

`endif

// File: sim.f
+incdir+hw
hw/pm_pkg.sv
hw/pm_max_tree.sv
hw/pm_metric_regs.sv
hw/pm_normalize_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pm_checker.sv
testbench/tb_pm_normalize.sv

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_an_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;
    localparam int RELEASE_SKEW = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release lines up with the stimulus slot after an edge
    initial begin
        rst_an_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #RELEASE_SKEW rst_an_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_pm_checker.sv
`default_nettype none
`include "pm_settings.svh"

module tb_pm_checker (
    input  logic               clk_i,
    input  logic               rst_an_i,
    input  logic               en_i,
    input  logic               clear_i,
    input  pm_pkg::mode_t      mode_i,
    input  pm_pkg::metric_t    pm_i [0:`PM_NUM_STATES-1],
    input  pm_pkg::metric_t    pm_nom_i [0:`PM_NUM_STATES-1],
    input  pm_pkg::state_idx_t best_state_i,
    output int                 error_cnt_o,
    output int                 check_cnt_o
);

    // Shadow of the DUT registers
    pm_pkg::metric_t    exp_nom [0:`PM_NUM_STATES-1] = '{default: '0};
    pm_pkg::state_idx_t exp_best = '0;
    pm_pkg::metric_t    next_nom [0:`PM_NUM_STATES-1];
    pm_pkg::state_idx_t next_best;
    logic               armed = 1'b0;
    int                 errors = 0;
    int                 checks = 0;

    assign error_cnt_o = errors;
    assign check_cnt_o = checks;

    // ------------------------------------------------------------
    // Expected registers after one strobe
    // ------------------------------------------------------------
    function automatic void ref_normalize(
        input  pm_pkg::metric_t    pm [0:`PM_NUM_STATES-1],
        input  pm_pkg::mode_t      mode,
        input  pm_pkg::metric_t    old_nom [0:`PM_NUM_STATES-1],
        output pm_pkg::metric_t    new_nom [0:`PM_NUM_STATES-1],
        output pm_pkg::state_idx_t idx
    );
        int n_active;
        int best;
        int diff;
        n_active = `PM_NUM_STATES >> int'(mode);
        best = int'(pm[0]);
        idx = '0;
        // Strictly greater, so the first maximum keeps its index
        for (int s = 1; s < n_active; s++) begin
            if (int'(pm[s]) > best) begin
                best = int'(pm[s]);
                idx = pm_pkg::state_idx_t'(s);
            end
        end
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            if (s < n_active) begin
                diff = int'(pm[s]) - best;
                if (diff > `PM_SAT_HI) diff = `PM_SAT_HI;
                if (diff < `PM_SAT_LO) diff = `PM_SAT_LO;
                new_nom[s] = pm_pkg::metric_t'(diff);
            end else begin
                new_nom[s] = old_nom[s];
            end
        end
    endfunction

    // Inputs are stable at the rising edge
    always @(posedge clk_i or negedge rst_an_i) begin
        armed = 1'b1;
        if (!rst_an_i || clear_i) begin
            exp_nom = '{default: '0};
            exp_best = '0;
        end else if (en_i) begin
            ref_normalize(pm_i, mode_i, exp_nom, next_nom, next_best);
            exp_nom = next_nom;
            exp_best = next_best;
        end
    end

    // ------------------------------------------------------------
    // Compare mid cycle
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (armed) begin
            checks++;
            for (int s = 0; s < `PM_NUM_STATES; s++) begin
                if (pm_nom_i[s] !== exp_nom[s]) begin
                    errors++;
                    $display("FAIL t=%0t pm_nom_o[%0d] expected %0d actual %0d",
                             $time, s, exp_nom[s], pm_nom_i[s]);
                end
            end
            if (best_state_i !== exp_best) begin
                errors++;
                $display("FAIL t=%0t best_state_o expected %0d actual %0d",
                         $time, exp_best, best_state_i);
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_pm_normalize.sv
`default_nettype none
`include "pm_settings.svh"

module tb_pm_normalize;

    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_TIMEOUT = 64;
    localparam int CHECK_TIMEOUT = 8;

    logic               clk;
    logic               rst_an;
    logic               en;
    logic               clear;
    pm_pkg::mode_t      mode;
    pm_pkg::metric_t    pm [0:`PM_NUM_STATES-1];
    pm_pkg::metric_t    pm_nom [0:`PM_NUM_STATES-1];
    pm_pkg::state_idx_t best_state;
    int                 error_cnt;
    int                 check_cnt;
    int                 timeout_cnt = 0;
    int                 seed = 32'he618_3aa6;

    tb_clock_gen u_clock_gen (
        .clk_o    (clk),
        .rst_an_o (rst_an)
    );

    pm_normalize_top UUT (
        .clk_i        (clk),
        .rst_an_i     (rst_an),
        .en_i         (en),
        .clear_i      (clear),
        .mode_i       (mode),
        .pm_i         (pm),
        .pm_nom_o     (pm_nom),
        .best_state_o (best_state)
    );

    tb_pm_checker u_checker (
        .clk_i        (clk),
        .rst_an_i     (rst_an),
        .en_i         (en),
        .clear_i      (clear),
        .mode_i       (mode),
        .pm_i         (pm),
        .pm_nom_i     (pm_nom),
        .best_state_i (best_state),
        .error_cnt_o  (error_cnt),
        .check_cnt_o  (check_cnt)
    );

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst_an && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!rst_an) begin
            $display("Timeout: reset still asserted after %0d cycles", n);
            timeout_cnt++;
        end
        #DRIVE_DELAY;
    endtask

    // Holds the inputs over one rising edge
    task automatic apply(input pm_pkg::mode_t m, input logic e, input logic c);
        mode = m;
        en = e;
        clear = c;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic fill_random(input int span);
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            pm[s] = pm_pkg::metric_t'($random(seed) % span);
        end
    endtask

    task automatic fill_const(input int value);
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            pm[s] = pm_pkg::metric_t'(value);
        end
    endtask

    task automatic run_random(input pm_pkg::mode_t m, input int count, input int span);
        repeat (count) begin
            fill_random(span);
            apply(m, 1'b1, 1'b0);
        end
    endtask

    task automatic wait_checks(input int count);
        int target;
        int n;
        target = check_cnt + count;
        n = 0;
        while (check_cnt < target && n < CHECK_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (check_cnt < target) begin
            $display("Timeout: checker compared nothing for %0d cycles", n);
            timeout_cnt++;
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        en = 1'b0;
        clear = 1'b0;
        mode = pm_pkg::MODE_64;
        pm = '{default: '0};

        wait_reset_release();
        apply(pm_pkg::MODE_64, 1'b0, 1'b0);

        // Full trellis, wide and narrow spread
        run_random(pm_pkg::MODE_64, 20, 256);
        run_random(pm_pkg::MODE_64, 20, 64);

        run_random(pm_pkg::MODE_32, 10, 128);
        run_random(pm_pkg::MODE_16, 10, 128);
        run_random(pm_pkg::MODE_8, 10, 128);

        // Larger metrics outside the active range
        fill_const(-20);
        pm[40] = 200;
        pm[3] = 10;
        apply(pm_pkg::MODE_8, 1'b1, 1'b0);
        pm[12] = 100;
        apply(pm_pkg::MODE_8, 1'b1, 1'b0);
        pm[33] = 150;
        apply(pm_pkg::MODE_32, 1'b1, 1'b0);

        // Deep negative differences
        fill_const(-256);
        pm[0] = 255;
        apply(pm_pkg::MODE_64, 1'b1, 1'b0);
        pm[63] = 255;
        pm[1] = -120;
        apply(pm_pkg::MODE_64, 1'b1, 1'b0);

        // Ties
        fill_const(-100);
        pm[5] = 50;
        pm[20] = 50;
        apply(pm_pkg::MODE_64, 1'b1, 1'b0);
        fill_const(7);
        apply(pm_pkg::MODE_16, 1'b1, 1'b0);
        fill_const(-30);
        pm[9] = -5;
        pm[13] = -5;
        pm[2] = -6;
        apply(pm_pkg::MODE_16, 1'b1, 1'b0);

        // Hold while en is low
        run_random(pm_pkg::MODE_64, 1, 256);
        repeat (5) begin
            fill_random(256);
            apply(pm_pkg::MODE_32, 1'b0, 1'b0);
        end

        // Clear beats en
        fill_random(256);
        apply(pm_pkg::MODE_64, 1'b1, 1'b1);
        apply(pm_pkg::MODE_64, 1'b0, 1'b0);
        run_random(pm_pkg::MODE_32, 3, 256);
        apply(pm_pkg::MODE_32, 1'b0, 1'b1);
        run_random(pm_pkg::MODE_64, 4, 256);

        en = 1'b0;
        wait_checks(2);

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_cnt, error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
